// ==== hw/cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui
    } aluOp_t;

    // Operand source when a later stage holds a newer value
    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSel_t;

    // Primary opcodes
    localparam opcode_t opSpecial = 6'h00;
    localparam opcode_t opJ       = 6'h02;
    localparam opcode_t opBeq     = 6'h04;
    localparam opcode_t opBne     = 6'h05;
    localparam opcode_t opAddiu   = 6'h09;
    localparam opcode_t opOri     = 6'h0d;
    localparam opcode_t opLui     = 6'h0f;
    localparam opcode_t opLw      = 6'h23;
    localparam opcode_t opSw      = 6'h2b;

    // SPECIAL function codes
    localparam funct_t fnSll  = 6'h00;
    localparam funct_t fnAddu = 6'h21;
    localparam funct_t fnSubu = 6'h23;
    localparam funct_t fnAnd  = 6'h24;
    localparam funct_t fnOr   = 6'h25;
    localparam funct_t fnSlt  = 6'h2a;

    // Forward mux shared by the decode and execute operands
    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal, word_t wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

endpackage

// ==== hw/pipeCtrl.sv ====
`timescale 1ns/100ps

module pipeCtrl (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::word_t    instrDec,
    input  cpuPkg::regAddr_t exDest,
    input  cpuPkg::regAddr_t memDest,
    input  logic             exRegWrite,
    input  logic             exMemToReg,
    input  logic             memRegWrite,
    input  logic             memMemToReg,
    input  logic             wbRegWrite,
    input  cpuPkg::regAddr_t wbDest,
    output logic             stall,
    output logic             regWrite,
    output logic             memToReg,
    output logic             memWrite,
    output logic             aluSrcImm,
    output logic             regDstRd,
    output logic             signExt,
    output logic             isBranch,
    output logic             branchNe,
    output logic             isJump,
    output cpuPkg::aluOp_t   aluOp,
    output cpuPkg::fwdSel_t  fwdDecA,
    output cpuPkg::fwdSel_t  fwdDecB,
    output cpuPkg::fwdSel_t  fwdExA,
    output cpuPkg::fwdSel_t  fwdExB
);
    import cpuPkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rsEx;
    regAddr_t rtEx;
    logic     usesRs;
    logic     usesRt;
    logic     exHit;
    logic     memHit;

    assign opcode = instrDec[31:26];
    assign funct  = instrDec[5:0];
    assign rs     = instrDec[25:21];
    assign rt     = instrDec[20:16];

    // Loads in the memory stage are never forwarded
    function automatic fwdSel_t fwdFor(regAddr_t src);
        if (src != '0 && memRegWrite && !memMemToReg && memDest == src) begin
            return fwdMem;
        end
        if (src != '0 && wbRegWrite && wbDest == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        regWrite  = 1'b0;
        memToReg  = 1'b0;
        memWrite  = 1'b0;
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        regDstRd  = 1'b0;
        signExt   = 1'b0;
        isBranch  = 1'b0;
        branchNe  = 1'b0;
        isJump    = 1'b0;
        usesRs    = 1'b0;
        usesRt    = 1'b0;
        case (opcode)
            opSpecial: begin
                regDstRd = 1'b1;
                case (funct)
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    fnSll:   aluOp = aluSll;
                    default: aluOp = aluAdd;
                endcase
                // Unknown function codes stay no-ops
                regWrite = funct inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt, fnSll};
                usesRs   = regWrite && funct != fnSll;
                usesRt   = regWrite;
            end
            opAddiu, opOri, opLui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                signExt   = opcode == opAddiu;
                usesRs    = opcode != opLui;
                aluOp     = opcode == opOri ? aluOr : (opcode == opLui ? aluLui : aluAdd);
            end
            opLw, opSw: begin
                regWrite  = opcode == opLw;
                memToReg  = opcode == opLw;
                memWrite  = opcode == opSw;
                aluSrcImm = 1'b1;
                signExt   = 1'b1;
                usesRs    = 1'b1;
                usesRt    = opcode == opSw;
            end
            opBeq, opBne: begin
                isBranch = 1'b1;
                branchNe = opcode == opBne;
                signExt  = 1'b1;
                usesRs   = 1'b1;
                usesRt   = 1'b1;
            end
            opJ:     isJump = 1'b1;
            default: ;
        endcase
    end

    assign exHit  = exDest != '0 && ((usesRs && exDest == rs) || (usesRt && exDest == rt));
    assign memHit = memDest != '0 && ((usesRs && memDest == rs) || (usesRt && memDest == rt));

    // Load-use or a branch whose operand is not ready yet
    assign stall = (exRegWrite && exHit && (exMemToReg || isBranch))
                || (isBranch && memRegWrite && memMemToReg && memHit);

    always_comb begin
        fwdDecA = fwdFor(rs);
        fwdDecB = fwdFor(rt);
        fwdExA  = fwdFor(rsEx);
        fwdExB  = fwdFor(rtEx);
    end

    // Source fields follow the instruction into execute and a bubble reads r0
    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            rsEx <= '0;
            rtEx <= '0;
        end else begin
            rsEx <= rs;
            rtEx <= rt;
        end
    end

endmodule

// ==== hw/fetchUnit.sv ====
`timescale 1ns/100ps

module fetchUnit #(
    parameter cpuPkg::word_t resetVector = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,
    input  cpuPkg::word_t instrDec,
    input  cpuPkg::word_t pcPlus4Dec,
    input  cpuPkg::word_t opA,
    input  cpuPkg::word_t opB,
    input  logic          isBranch,
    input  logic          branchNe,
    input  logic          isJump,
    output cpuPkg::word_t pc,
    output cpuPkg::word_t pcPlus4
);
    import cpuPkg::*;

    word_t branchTarget;
    word_t jumpTarget;
    word_t nextPc;
    logic  branchTaken;

    assign pcPlus4 = pc + 32'd4;

    // Equality on the forwarded decode operands
    assign branchTaken = isBranch && ((opA == opB) != branchNe);

    // Both targets are relative to the delay slot
    assign branchTarget = pcPlus4Dec + {{14{instrDec[15]}}, instrDec[15:0], 2'b00};
    assign jumpTarget   = {pcPlus4Dec[31:28], instrDec[25:0], 2'b00};

    always_comb begin
        if (isJump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetVector;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  logic             writeEn,
    input  cpuPkg::regAddr_t readAddrA,
    input  cpuPkg::regAddr_t readAddrB,
    input  cpuPkg::regAddr_t writeAddr,
    input  cpuPkg::word_t    writeData,
    output cpuPkg::word_t    readDataA,
    output cpuPkg::word_t    readDataB
);
    import cpuPkg::*;

    word_t regs [32];

    // Decode forwarding picks up the value being written back
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/100ps

module execUnit (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::word_t    rsVal,
    input  cpuPkg::word_t    rtVal,
    input  cpuPkg::word_t    imm,
    input  cpuPkg::word_t    memResult,
    input  cpuPkg::word_t    wbResult,
    input  logic [4:0]       shamt,
    input  cpuPkg::fwdSel_t  fwdExA,
    input  cpuPkg::fwdSel_t  fwdExB,
    input  cpuPkg::aluOp_t   aluOp,
    input  logic             aluSrcImm,
    input  logic             regWriteIn,
    input  logic             memToRegIn,
    input  logic             memWriteIn,
    input  cpuPkg::regAddr_t destIn,
    output cpuPkg::word_t    aluResult,
    output cpuPkg::word_t    storeData,
    output logic             regWriteOut,
    output logic             memToRegOut,
    output logic             memWriteOut,
    output cpuPkg::regAddr_t destOut
);
    import cpuPkg::*;

    word_t opA;
    word_t rtFwd;
    word_t opB;
    word_t result;

    assign opA   = fwdMux(fwdExA, rsVal, memResult, wbResult);
    assign rtFwd = fwdMux(fwdExB, rtVal, memResult, wbResult);
    assign opB   = aluSrcImm ? imm : rtFwd;

    always_comb begin
        case (aluOp)
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            // sll shifts rt, which sits on operand B
            aluSll:  result = opB << shamt;
            aluLui:  result = {opB[15:0], 16'h0000};
            default: result = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteOut <= 1'b0;
            memToRegOut <= 1'b0;
            memWriteOut <= 1'b0;
        end else begin
            regWriteOut <= regWriteIn;
            memToRegOut <= memToRegIn;
            memWriteOut <= memWriteIn;
        end
    end

    always_ff @(posedge clk) begin
        aluResult <= result;
        storeData <= rtFwd;
        destOut   <= destIn;
    end

endmodule

// ==== hw/mipsCore.sv ====
`timescale 1ns/100ps

module mipsCore #(
    parameter cpuPkg::word_t resetVector = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rstN,
    input  cpuPkg::word_t instr,
    input  cpuPkg::word_t dataRData,
    output cpuPkg::word_t instrAddr,
    output cpuPkg::word_t dataAddr,
    output cpuPkg::word_t dataWData,
    output logic          dataWe
);
    import cpuPkg::*;

    // Fetch and IF/ID
    word_t    pcPlus4F;
    word_t    instrD;
    word_t    pcPlus4D;

    // Decode
    logic     stall;
    logic     decRegWrite;
    logic     decMemToReg;
    logic     decMemWrite;
    logic     decAluSrcImm;
    logic     regDstRd;
    logic     signExt;
    logic     isBranch;
    logic     branchNe;
    logic     isJump;
    aluOp_t   decAluOp;
    fwdSel_t  fwdDecA;
    fwdSel_t  fwdDecB;
    fwdSel_t  fwdExA;
    fwdSel_t  fwdExB;
    word_t    rfA;
    word_t    rfB;
    word_t    opA;
    word_t    opB;
    word_t    immD;
    regAddr_t destD;

    // ID/EX
    logic     exRegWrite;
    logic     exMemToReg;
    logic     exMemWrite;
    logic     exAluSrcImm;
    aluOp_t   exAluOp;
    word_t    exRsVal;
    word_t    exRtVal;
    word_t    exImm;
    logic [4:0] exShamt;
    regAddr_t exDest;

    // EX/MEM and MEM/WB
    word_t    memAluResult;
    word_t    memStoreData;
    logic     memRegWrite;
    logic     memMemToReg;
    logic     memMemWrite;
    regAddr_t memDest;
    logic     wbRegWrite;
    logic     wbMemToReg;
    word_t    wbAluResult;
    word_t    wbLoadData;
    regAddr_t wbDest;
    word_t    wbResult;

    fetchUnit #(.resetVector(resetVector)) fetch0 (
        .clk(clk), .rstN(rstN), .stall(stall),
        .instrDec(instrD), .pcPlus4Dec(pcPlus4D), .opA(opA), .opB(opB),
        .isBranch(isBranch), .branchNe(branchNe), .isJump(isJump),
        .pc(instrAddr), .pcPlus4(pcPlus4F)
    );

    // Delay slot always runs, so IF/ID is never flushed
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrD <= '0;
        end else if (!stall) begin
            instrD <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcPlus4D <= pcPlus4F;
        end
    end

    pipeCtrl ctrl0 (
        .clk(clk), .rstN(rstN), .instrDec(instrD),
        .exDest(exDest), .memDest(memDest),
        .exRegWrite(exRegWrite), .exMemToReg(exMemToReg),
        .memRegWrite(memRegWrite), .memMemToReg(memMemToReg),
        .wbRegWrite(wbRegWrite), .wbDest(wbDest), .stall(stall),
        .regWrite(decRegWrite), .memToReg(decMemToReg), .memWrite(decMemWrite),
        .aluSrcImm(decAluSrcImm), .regDstRd(regDstRd), .signExt(signExt),
        .isBranch(isBranch), .branchNe(branchNe), .isJump(isJump), .aluOp(decAluOp),
        .fwdDecA(fwdDecA), .fwdDecB(fwdDecB), .fwdExA(fwdExA), .fwdExB(fwdExB)
    );

    regFile regs0 (
        .clk(clk), .rstN(rstN), .writeEn(wbRegWrite),
        .readAddrA(instrD[25:21]), .readAddrB(instrD[20:16]),
        .writeAddr(wbDest), .writeData(wbResult),
        .readDataA(rfA), .readDataB(rfB)
    );

    assign opA   = fwdMux(fwdDecA, rfA, memAluResult, wbResult);
    assign opB   = fwdMux(fwdDecB, rfB, memAluResult, wbResult);
    assign immD  = {signExt ? {16{instrD[15]}} : 16'h0000, instrD[15:0]};
    assign destD = regDstRd ? instrD[15:11] : instrD[20:16];

    // A stall leaves a bubble in execute
    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            exRegWrite  <= 1'b0;
            exMemToReg  <= 1'b0;
            exMemWrite  <= 1'b0;
            exAluSrcImm <= 1'b0;
            exAluOp     <= aluAdd;
        end else begin
            exRegWrite  <= decRegWrite;
            exMemToReg  <= decMemToReg;
            exMemWrite  <= decMemWrite;
            exAluSrcImm <= decAluSrcImm;
            exAluOp     <= decAluOp;
        end
    end

    always_ff @(posedge clk) begin
        exRsVal <= opA;
        exRtVal <= opB;
        exImm   <= immD;
        exShamt <= instrD[10:6];
        exDest  <= destD;
    end

    execUnit exec0 (
        .clk(clk), .rstN(rstN), .rsVal(exRsVal), .rtVal(exRtVal), .imm(exImm),
        .memResult(memAluResult), .wbResult(wbResult), .shamt(exShamt),
        .fwdExA(fwdExA), .fwdExB(fwdExB), .aluOp(exAluOp), .aluSrcImm(exAluSrcImm),
        .regWriteIn(exRegWrite), .memToRegIn(exMemToReg), .memWriteIn(exMemWrite),
        .destIn(exDest), .aluResult(memAluResult), .storeData(memStoreData),
        .regWriteOut(memRegWrite), .memToRegOut(memMemToReg),
        .memWriteOut(memMemWrite), .destOut(memDest)
    );

    assign dataAddr  = memAluResult;
    assign dataWData = memStoreData;
    assign dataWe    = memMemWrite;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbMemToReg <= memMemToReg;
        end
    end

    always_ff @(posedge clk) begin
        wbAluResult <= memAluResult;
        wbLoadData  <= dataRData;
        wbDest      <= memDest;
    end

    assign wbResult = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

// ==== sim/mipsCore_asserts.sv ====
`timescale 1ns/100ps

module mipsCore_asserts #(
    parameter cpuPkg::word_t resetVector = 32'h0000_0000
) (
    input logic          clk,
    input logic          rstN,
    input cpuPkg::word_t instrAddr,
    input logic          dataWe,
    input logic          stall
);

    int failCount = 0;

    // Reset holds the PC at the vector and keeps stores off
    pcOnReset: assert property (@(posedge clk) !rstN |=> instrAddr == resetVector)
        else begin
            failCount++;
            $error("instrAddr differs from the reset vector during reset");
        end

    noStoreOnReset: assert property (@(posedge clk) !rstN |=> !dataWe)
        else begin
            failCount++;
            $error("dataWe high during reset");
        end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) instrAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instrAddr not word aligned");
        end

    singleStall: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
        else begin
            failCount++;
            $error("stall held for two cycles in a row");
        end

endmodule

bind mipsCore mipsCore_asserts #(.resetVector(resetVector)) asserts0 (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .dataWe(dataWe), .stall(stall)
);

// ==== sim/mipsCoreTb.sv ====
`timescale 1ns/100ps

module mipsCoreTb;
    import cpuPkg::*;

    localparam word_t resetVector = 32'h0000_0400;
    localparam word_t poisonAddr  = 32'h0000_00f0;
    localparam int    resetCycles = 16;

    logic  clk;
    logic  rstN;
    word_t instr;
    word_t dataRData;
    word_t instrAddr;
    word_t dataAddr;
    word_t dataWData;
    logic  dataWe;

    // One program table row per instruction with its optional store
    word_t progInstr[$];
    logic  progHasStore[$];
    word_t progStoreAddr[$];
    word_t progStoreData[$];

    word_t rom [256];
    word_t ram [128];
    word_t expAddrQ[$];
    word_t expDataQ[$];
    word_t nextStoreAddr;
    int    progLen = 0;

    mipsCore #(.resetVector(resetVector)) dut0 (
        .clk(clk), .rstN(rstN), .instr(instr), .dataRData(dataRData),
        .instrAddr(instrAddr), .dataAddr(dataAddr), .dataWData(dataWData),
        .dataWe(dataWe)
    );

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abortRun();
        end
    endtask

    function automatic word_t rType(funct_t fn, int rs, int rt, int rd, int sh);
        return {opSpecial, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t iType(opcode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t fetchWord(word_t addr);
        word_t idx;
        idx = (addr - resetVector) >> 2;
        if (idx < progLen) begin
            return rom[idx];
        end
        return 32'h0000_0000;
    endfunction

    task automatic addRow(word_t ins, logic hasStore, word_t addr, word_t data);
        progInstr.push_back(ins);
        progHasStore.push_back(hasStore);
        progStoreAddr.push_back(addr);
        progStoreData.push_back(data);
    endtask

    task automatic emit(word_t ins);
        addRow(ins, 1'b0, '0, '0);
    endtask

    task automatic emitNops(int n);
        repeat (n) emit(32'h0000_0000);
    endtask

    // sw of one register into the next result slot
    task automatic storeReg(int r, word_t exp);
        addRow(iType(opSw, 0, r, nextStoreAddr), 1'b1, nextStoreAddr, exp);
        nextStoreAddr += 4;
    endtask

    // Must never run since its store would break the store order
    task automatic emitSkipped();
        emit(iType(opSw, 0, 1, poisonAddr));
    endtask

    // Jump over the delay slot and one skipped instruction
    task automatic emitJump();
        word_t target;
        target = resetVector + (progInstr.size() + 3) * 4;
        emit({opJ, target[27:2]});
    endtask

    task automatic buildProgram();
        word_t a;
        word_t b;
        word_t c;
        word_t sum;
        word_t f1;
        word_t f2;
        word_t f3;
        word_t f4;
        a   = 32'h0000_1234;
        b   = 32'hffff_fff0;
        c   = 32'ha5c3_0f0f;
        sum = a + b;
        f1  = a + sum;
        f2  = f1 - b;
        f3  = f1 | f2;
        f4  = f1 + f3;
        nextStoreAddr = 32'h0000_0100;

        emit(iType(opAddiu, 0, 1, 16'h1234));
        storeReg(1, a);
        emit(iType(opAddiu, 0, 2, 16'hfff0));
        storeReg(2, b);
        emit(iType(opLui, 0, 3, 16'ha5c3));
        storeReg(3, 32'ha5c3_0000);
        emit(iType(opOri, 3, 3, 16'h0f0f));
        storeReg(3, c);
        emit(rType(fnAddu, 1, 2, 4, 0));
        storeReg(4, sum);
        emit(rType(fnSubu, 1, 3, 5, 0));
        storeReg(5, a - c);
        emit(rType(fnAnd, 3, 2, 6, 0));
        storeReg(6, c & b);
        emit(rType(fnOr, 1, 3, 7, 0));
        storeReg(7, a | c);
        // b is negative and a positive
        emit(rType(fnSlt, 2, 1, 8, 0));
        storeReg(8, 32'h0000_0001);
        emit(rType(fnSlt, 1, 2, 9, 0));
        storeReg(9, 32'h0000_0000);
        emit(rType(fnSll, 0, 3, 10, 4));
        storeReg(10, c << 4);

        // Back to back chain followed by the same chain spaced out
        emit(rType(fnAddu, 1, 4, 11, 0));
        emit(rType(fnSubu, 11, 2, 12, 0));
        emit(rType(fnOr, 11, 12, 13, 0));
        emit(rType(fnAddu, 11, 13, 14, 0));
        storeReg(11, f1);
        storeReg(12, f2);
        storeReg(13, f3);
        storeReg(14, f4);
        emit(rType(fnAddu, 1, 4, 15, 0));
        emitNops(3);
        emit(rType(fnSubu, 15, 2, 16, 0));
        emitNops(3);
        emit(rType(fnOr, 15, 16, 17, 0));
        emitNops(3);
        emit(rType(fnAddu, 15, 17, 18, 0));
        emitNops(3);
        storeReg(15, f1);
        storeReg(16, f2);
        storeReg(17, f3);
        storeReg(18, f4);

        // Load-use
        emit(iType(opLw, 0, 19, 16'h0010));
        emit(rType(fnAddu, 19, 1, 20, 0));
        storeReg(20, ram[4] + a);
        emit(iType(opLw, 0, 21, 16'h0024));
        storeReg(21, ram[9]);

        // Branches resolve in decode with one delay slot
        emit(iType(opBeq, 1, 1, 2));
        storeReg(1, a);
        emitSkipped();
        emit(iType(opBne, 1, 1, 2));
        storeReg(2, b);
        storeReg(4, sum);
        emit(iType(opBeq, 1, 2, 2));
        storeReg(5, a - c);
        storeReg(6, c & b);
        emit(iType(opBne, 1, 2, 2));
        storeReg(7, a | c);
        emitSkipped();
        emit(iType(opAddiu, 0, 23, 16'h0005));
        emit(iType(opBne, 23, 0, 2));
        storeReg(23, 32'h0000_0005);
        emitSkipped();
        // Taken only when the loaded word matches r21
        emit(iType(opLw, 0, 22, 16'h0024));
        emitNops(1);
        emit(iType(opBeq, 22, 21, 2));
        storeReg(22, ram[9]);
        emitSkipped();
        emitJump();
        storeReg(11, f1);
        emitSkipped();
        storeReg(14, f4);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Bus responses follow the addresses of the current cycle
    initial begin
        forever begin
            @(posedge clk);
            #2;
            instr     = fetchWord(instrAddr);
            dataRData = ram[dataAddr[8:2]];
        end
    end

    always @(negedge clk) begin
        if (rstN && dataWe) begin
            if (expAddrQ.size() == 0) begin
                $display("Error: store to 0x%h after the last expected store", dataAddr);
                abortRun();
            end else begin
                checkWord("dataAddr", dataAddr, expAddrQ.pop_front());
                checkWord("dataWData", dataWData, expDataQ.pop_front());
                ram[dataAddr[8:2]] = dataWData;
            end
        end
    end

    always @(dut0.asserts0.failCount) begin
        if (dut0.asserts0.failCount != 0) begin
            $display("Error: a bound assertion failed");
            abortRun();
        end
    end

    initial begin
        wait (progLen > 0);
        repeat (progLen * 4 + 50) @(posedge clk);
        $display("Error: watchdog timeout, the program did not reach its end");
        abortRun();
    end

    initial begin
        rstN      = 1'b0;
        instr     = '0;
        dataRData = '0;
        void'($urandom(32'hbb4b9a27));
        foreach (ram[i]) begin
            ram[i] = $urandom();
        end
        buildProgram();
        for (int i = 0; i < progInstr.size(); i++) begin
            rom[i] = progInstr[i];
            if (progHasStore[i]) begin
                expAddrQ.push_back(progStoreAddr[i]);
                expDataQ.push_back(progStoreData[i]);
            end
        end
        progLen = progInstr.size();

        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            #2;
            checkWord("instrAddr", instrAddr, resetVector);
            if (dataWe !== 1'b0) begin
                $display("Error: dataWe is not low during reset");
                abortRun();
            end
        end
        rstN = 1'b1;

        // Fetch past the last row and let the pipeline drain
        wait (instrAddr == resetVector + progLen * 4);
        repeat (10) @(posedge clk);
        if (expAddrQ.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Error: %0d expected stores never happened", expAddrQ.size());
            abortRun();
        end
    end

endmodule

// ==== src.f ====
hw/cpuPkg.sv
hw/pipeCtrl.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/execUnit.sv
hw/mipsCore.sv
sim/mipsCore_asserts.sv
sim/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mipscore

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/pipeCtrl.sv
      - hw/fetchUnit.sv
      - hw/regFile.sv
      - hw/execUnit.sv
      - hw/mipsCore.sv
  - target: simulation
    files:
      - sim/mipsCore_asserts.sv
      - sim/mipsCoreTb.sv
